/* regServer.f */
src/srvPkg.sv
src/uartRx.sv
src/uartTx.sv
src/cmdParser.sv
src/regAlu.sv
src/hexReply.sv
src/regServer.sv
tb/tbClock.sv
tb/tbServer.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the register server testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbServer -f regServer.f -o simServer

out=$(./obj_dir/simServer) || true
echo "$out"

if echo "$out" | grep -q "PASS: all tests"; then
  exit 0
fi
exit 1

/* src/cmdParser.sv */
`timescale 1ns/1ps

module cmdParser (
  input  logic                    clk,
  input  logic                    arstN,
  input  logic                    rxValid,
  input  logic [7:0]              rxData,
  input  logic                    doneValid,
  input  logic [31:0]             rdData,
  input  logic                    replyBusy,
  output logic                    opValid,
  output srvPkg::opE              op,
  output logic [srvPkg::SEL_W-1:0] dst,
  output logic [srvPkg::SEL_W-1:0] srcA,
  output logic [srvPkg::SEL_W-1:0] srcB,
  output logic [31:0]             wrData,
  output logic                    replyStart,
  output logic                    replyIsValue,
  output logic [31:0]             replyValue,
  output logic [7:0]              replyCode
);

  typedef enum logic [2:0] {P_CMD, P_DST, P_SRCA, P_SRCB, P_HEX, P_END, P_BAD} pStateE;

  pStateE                    state;
  logic [srvPkg::LINE_W-1:0] lineCnt;
  logic [2:0]                hexCnt;
  logic                      byteIn;
  logic                      isCr;
  logic                      isSpace;
  logic                      fieldByte;
  logic                      regOk;
  logic [4:0]                hexV;

  // bit 4 set when the byte is a hex digit
  function automatic logic [4:0] hexNib(input logic [7:0] c);
    logic [7:0] d;
    d = 8'h00;
    if (c >= 8'h30 && c <= 8'h39) d = c - 8'h30;
    else if (c >= 8'h41 && c <= 8'h46) d = c - 8'h37;
    else if (c >= 8'h61 && c <= 8'h66) d = c - 8'h57;
    else return 5'd0;
    return {1'b1, d[3:0]};
  endfunction

  assign byteIn    = rxValid && !replyBusy;  // host waits for the reply
  assign isCr      = (rxData == srvPkg::CHAR_CR);
  assign isSpace   = (rxData == srvPkg::CHAR_SPACE);
  assign fieldByte = byteIn && !isCr && !isSpace;
  assign regOk     = (rxData >= 8'h30) && (rxData <= 8'h37);
  assign hexV      = hexNib(rxData);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state        <= P_CMD;
      lineCnt      <= '0;
      hexCnt       <= '0;
      op           <= srvPkg::OP_WRITE;
      opValid      <= 1'b0;
      replyStart   <= 1'b0;
      replyIsValue <= 1'b0;
    end else begin
      opValid    <= 1'b0;
      replyStart <= 1'b0;
      if (doneValid) begin
        replyStart   <= 1'b1;
        replyIsValue <= (op == srvPkg::OP_READ);
      end
      if (byteIn) begin
        if (isCr) begin
          if (state == P_END) begin
            opValid <= 1'b1;
          end else begin
            replyStart   <= 1'b1;
            replyIsValue <= 1'b0;
          end
          state   <= P_CMD;
          lineCnt <= '0;
          hexCnt  <= '0;
        end else if (lineCnt == srvPkg::LINE_W'(srvPkg::MAX_LINE)) begin
          state <= P_BAD;  // too long, discard to CR
        end else begin
          lineCnt <= lineCnt + 1'b1;
          if (!isSpace) begin
            case (state)
              P_CMD: begin
                state <= P_DST;
                case (rxData)
                  srvPkg::CHAR_W: op <= srvPkg::OP_WRITE;
                  srvPkg::CHAR_R: op <= srvPkg::OP_READ;
                  srvPkg::CHAR_A: op <= srvPkg::OP_ADD;
                  srvPkg::CHAR_S: op <= srvPkg::OP_SUB;
                  srvPkg::CHAR_X: op <= srvPkg::OP_XOR;
                  default:        state <= P_BAD;
                endcase
              end
              P_DST: begin
                if (!regOk) state <= P_BAD;
                else if (op == srvPkg::OP_WRITE) state <= P_HEX;
                else if (op == srvPkg::OP_READ) state <= P_END;
                else state <= P_SRCA;
              end
              P_SRCA: state <= regOk ? P_SRCB : P_BAD;
              P_SRCB: state <= regOk ? P_END : P_BAD;
              P_HEX: begin
                if (hexV[4]) begin
                  hexCnt <= hexCnt + 1'b1;
                  if (hexCnt == 3'd7) state <= P_END;
                end else begin
                  state <= P_BAD;
                end
              end
              default: state <= P_BAD;  // trailing junk
            endcase
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fieldByte && state == P_DST) dst <= rxData[srvPkg::SEL_W-1:0];
    if (fieldByte && state == P_SRCA) srcA <= rxData[srvPkg::SEL_W-1:0];
    if (fieldByte && state == P_SRCB) srcB <= rxData[srvPkg::SEL_W-1:0];
    if (fieldByte && state == P_HEX) wrData <= {wrData[27:0], hexV[3:0]};
    if (doneValid) begin
      replyValue <= rdData;
      replyCode  <= srvPkg::CHAR_OK;
    end else if (byteIn && isCr && state != P_END) begin
      replyCode <= srvPkg::CHAR_BAD;
    end
  end

endmodule

/* src/hexReply.sv */
`timescale 1ns/1ps

module hexReply (
  input  logic        clk,
  input  logic        arstN,
  input  logic        replyStart,
  input  logic        replyIsValue,
  input  logic [31:0] replyValue,
  input  logic [7:0]  replyCode,
  input  logic        txBusy,
  output logic        txStart,
  output logic [7:0]  txData,
  output logic        replyBusy
);

  logic [3:0]  idx;
  logic [3:0]  lastIdx;
  logic        isValueR;
  logic [31:0] valueR;
  logic [7:0]  codeR;
  logic [3:0]  nib;
  logic [7:0]  nextChar;
  logic        handOver;

  assign lastIdx  = isValueR ? 4'd8 : 4'd1;  // CR position
  assign nib      = valueR[31:28];
  assign handOver = replyBusy && !txBusy && !txStart;

  always_comb begin
    if (idx == lastIdx) nextChar = srvPkg::CHAR_CR;
    else if (!isValueR) nextChar = codeR;
    else if (nib < 4'd10) nextChar = 8'h30 + {4'h0, nib};
    else nextChar = 8'h37 + {4'h0, nib};  // upper case A-F
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      replyBusy <= 1'b0;
      txStart   <= 1'b0;
      idx       <= '0;
      isValueR  <= 1'b0;
    end else begin
      txStart <= 1'b0;
      if (replyStart) begin
        replyBusy <= 1'b1;
        idx       <= '0;
        isValueR  <= replyIsValue;
      end else if (handOver) begin
        txStart <= 1'b1;
        idx     <= idx + 1'b1;
        if (idx == lastIdx) replyBusy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (replyStart) begin
      valueR <= replyValue;
      codeR  <= replyCode;
    end else if (handOver) begin
      valueR <= {valueR[27:0], 4'h0};  // next nibble to the top
      txData <= nextChar;
    end
  end

endmodule

/* src/regAlu.sv */
`timescale 1ns/1ps

module regAlu (
  input  logic                     clk,
  input  logic                     arstN,
  input  logic                     opValid,
  input  srvPkg::opE               op,
  input  logic [srvPkg::SEL_W-1:0] dst,
  input  logic [srvPkg::SEL_W-1:0] srcA,
  input  logic [srvPkg::SEL_W-1:0] srcB,
  input  logic [31:0]              wrData,
  output logic                     doneValid,
  output logic [31:0]              rdData
);

  logic [srvPkg::REG_W-1:0] regs [srvPkg::NUM_REGS];
  logic [srvPkg::REG_W-1:0] aluOut;

  always_comb begin
    case (op)
      srvPkg::OP_ADD:   aluOut = regs[srcA] + regs[srcB];  // wraps at 32 bits
      srvPkg::OP_SUB:   aluOut = regs[srcA] - regs[srcB];
      srvPkg::OP_XOR:   aluOut = regs[srcA] ^ regs[srcB];
      srvPkg::OP_WRITE: aluOut = wrData;
      default:          aluOut = regs[dst];
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      doneValid <= 1'b0;
      for (int i = 0; i < srvPkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      doneValid <= opValid;
      if (opValid && op != srvPkg::OP_READ) regs[dst] <= aluOut;
    end
  end

  always_ff @(posedge clk) begin
    if (opValid) rdData <= aluOut;  // read value or new dst value
  end

  opLegal: assert property (@(posedge clk) disable iff (!arstN)
    opValid |-> op inside {srvPkg::OP_WRITE, srvPkg::OP_READ, srvPkg::OP_ADD,
                           srvPkg::OP_SUB, srvPkg::OP_XOR})
    else $error("Error op code not defined: %h", op);

endmodule

/* src/regServer.sv */
`timescale 1ns/1ps

module regServer (
  input  logic clk,
  input  logic arstN,
  input  logic rxd,
  output logic txd
);

  logic                     rxValid;
  logic [7:0]               rxData;
  logic                     opValid;
  srvPkg::opE               op;
  logic [srvPkg::SEL_W-1:0] dst;
  logic [srvPkg::SEL_W-1:0] srcA;
  logic [srvPkg::SEL_W-1:0] srcB;
  logic [31:0]              wrData;
  logic                     doneValid;
  logic [31:0]              rdData;
  logic                     replyStart;
  logic                     replyIsValue;
  logic [31:0]              replyValue;
  logic [7:0]               replyCode;
  logic                     replyBusy;
  logic                     txStart;
  logic [7:0]               txData;
  logic                     txBusy;

  uartRx u_rx (
    .clk(clk), .arstN(arstN), .rxd(rxd), .rxValid(rxValid), .rxData(rxData)
  );

  cmdParser u_parser (
    .clk(clk), .arstN(arstN), .rxValid(rxValid), .rxData(rxData),
    .doneValid(doneValid), .rdData(rdData), .replyBusy(replyBusy),
    .opValid(opValid), .op(op), .dst(dst), .srcA(srcA), .srcB(srcB),
    .wrData(wrData), .replyStart(replyStart), .replyIsValue(replyIsValue),
    .replyValue(replyValue), .replyCode(replyCode)
  );

  regAlu u_alu (
    .clk(clk), .arstN(arstN), .opValid(opValid), .op(op), .dst(dst),
    .srcA(srcA), .srcB(srcB), .wrData(wrData), .doneValid(doneValid),
    .rdData(rdData)
  );

  hexReply u_reply (
    .clk(clk), .arstN(arstN), .replyStart(replyStart),
    .replyIsValue(replyIsValue), .replyValue(replyValue),
    .replyCode(replyCode), .txBusy(txBusy), .txStart(txStart),
    .txData(txData), .replyBusy(replyBusy)
  );

  uartTx u_tx (
    .clk(clk), .arstN(arstN), .txStart(txStart), .txData(txData),
    .txd(txd), .txBusy(txBusy)
  );

endmodule

/* src/srvPkg.sv */
package srvPkg;

  // serial bit timing, kept short for simulation
  localparam int CLKS_PER_BIT = 16;
  localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

  // register file geometry
  localparam int NUM_REGS = 8;
  localparam int REG_W    = 32;
  localparam int SEL_W    = 3;

  // command line limit
  localparam int MAX_LINE = 40;
  localparam int LINE_W   = $clog2(MAX_LINE + 1);

  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_ADD,
    OP_SUB,
    OP_XOR
  } opE;

  localparam logic [7:0] CHAR_CR    = 8'h0D;
  localparam logic [7:0] CHAR_SPACE = 8'h20;
  localparam logic [7:0] CHAR_OK    = 8'h4B;  // K
  localparam logic [7:0] CHAR_BAD   = 8'h3F;  // ?
  localparam logic [7:0] CHAR_W     = 8'h57;
  localparam logic [7:0] CHAR_R     = 8'h52;
  localparam logic [7:0] CHAR_A     = 8'h41;
  localparam logic [7:0] CHAR_S     = 8'h53;
  localparam logic [7:0] CHAR_X     = 8'h58;

endpackage

/* src/uartRx.sv */
`timescale 1ns/1ps

module uartRx (
  input  logic       clk,
  input  logic       arstN,
  input  logic       rxd,
  output logic       rxValid,
  output logic [7:0] rxData
);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rxStateE;

  rxStateE                        state;
  logic [1:0]                     sync;
  logic [srvPkg::BIT_CNT_W-1:0]   cnt;
  logic [2:0]                     bitIdx;
  logic [7:0]                     shiftReg;
  logic                           rxS;
  logic                           sampleNow;

  assign rxS       = sync[1];
  assign sampleNow = (state == RX_DATA) &&
                     (cnt == srvPkg::BIT_CNT_W'(srvPkg::CLKS_PER_BIT - 1));
  assign rxData    = shiftReg;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      sync    <= 2'b11;
      state   <= RX_IDLE;
      cnt     <= '0;
      bitIdx  <= '0;
      rxValid <= 1'b0;
    end else begin
      sync    <= {sync[0], rxd};
      rxValid <= 1'b0;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (!rxS) state <= RX_START;
        end
        RX_START: begin
          if (cnt == srvPkg::BIT_CNT_W'(srvPkg::CLKS_PER_BIT / 2 - 1)) begin
            cnt    <= '0;
            bitIdx <= '0;
            state  <= rxS ? RX_IDLE : RX_DATA;  // glitch, not a start bit
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (sampleNow) begin
            cnt    <= '0;
            bitIdx <= bitIdx + 1'b1;
            if (bitIdx == 3'd7) state <= RX_STOP;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (cnt == srvPkg::BIT_CNT_W'(srvPkg::CLKS_PER_BIT - 1)) begin
            rxValid <= rxS;  // framing error drops the byte
            state   <= RX_IDLE;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (sampleNow) shiftReg <= {rxS, shiftReg[7:1]};  // lsb first
  end

  rxSinglePulse: assert property (@(posedge clk) disable iff (!arstN)
    rxValid |=> !rxValid)
    else $error("Error rxValid high on two consecutive cycles");

endmodule

/* src/uartTx.sv */
`timescale 1ns/1ps

module uartTx (
  input  logic       clk,
  input  logic       arstN,
  input  logic       txStart,
  input  logic [7:0] txData,
  output logic       txd,
  output logic       txBusy
);

  logic [9:0]                   shiftReg;
  logic [srvPkg::BIT_CNT_W-1:0] cnt;
  logic [3:0]                   bitIdx;

  assign txd = shiftReg[0];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      shiftReg <= '1;  // line idles high
      cnt      <= '0;
      bitIdx   <= '0;
      txBusy   <= 1'b0;
    end else if (txStart && !txBusy) begin
      shiftReg <= {1'b1, txData, 1'b0};  // stop, data, start
      cnt      <= '0;
      bitIdx   <= '0;
      txBusy   <= 1'b1;
    end else if (txBusy) begin
      if (cnt == srvPkg::BIT_CNT_W'(srvPkg::CLKS_PER_BIT - 1)) begin
        cnt      <= '0;
        shiftReg <= {1'b1, shiftReg[9:1]};
        if (bitIdx == 4'd9) begin
          txBusy <= 1'b0;  // stop bit done
        end else begin
          bitIdx <= bitIdx + 1'b1;
        end
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  txNoOverrun: assert property (@(posedge clk) disable iff (!arstN)
    txStart |-> !txBusy)
    else $error("Error txStart while txBusy");

endmodule

/* tb/tbClock.sv */
`timescale 1ns/1ps

module tbClock (
  output logic clk,
  output logic arstN
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    arstN = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arstN = 1'b1;
  end

endmodule

/* tb/tbServer.sv */
`timescale 1ns/1ps

module tbServer;

  localparam int NUM_RAND_OPS = 12;
  localparam int NUM_BAD      = 5;
  // reads, writes, ops and malformed lines over all four tests
  localparam int NUM_CMDS     = 8 + 16 + (4 + 6 + NUM_RAND_OPS + 8) + (NUM_BAD + 8);
  localparam longint WATCHDOG_NS = longint'(NUM_CMDS) * srvPkg::MAX_LINE * 10 *
                                   srvPkg::CLKS_PER_BIT * 10 * 3;
  localparam logic [71:0] OK_LINE  = {56'h0, srvPkg::CHAR_OK, srvPkg::CHAR_CR};
  localparam logic [71:0] BAD_LINE = {56'h0, srvPkg::CHAR_BAD, srvPkg::CHAR_CR};

  logic        clk;
  logic        arstN;
  logic        rxd;
  logic        txd;
  int          errors = 0;
  int          cmdCount = 0;
  logic [31:0] model [srvPkg::NUM_REGS];
  logic [71:0] replyQ [$];
  int          lenQ [$];
  wire  [31:0] probeReg [srvPkg::NUM_REGS];

  tbClock u_clk (.clk(clk), .arstN(arstN));

  regServer u_dut (.clk(clk), .arstN(arstN), .rxd(rxd), .txd(txd));

  for (genvar g = 0; g < srvPkg::NUM_REGS; g++) begin : gProbe
    assign probeReg[g] = u_dut.u_alu.regs[g];  // register file seen from outside
  end

  txIdleInReset: assert property (@(negedge clk) !arstN |-> txd)
    else begin
      errors++;
      $display("Error txd during reset: expected 1, got %h", txd);
    end

  function automatic logic [7:0] hexChar(input logic [3:0] nib);
    if (nib < 4'd10) return 8'h30 + 8'(nib);
    return 8'h41 + 8'(nib) - 8'd10;  // upper case
  endfunction

  function automatic logic [71:0] valueLine(input logic [31:0] v);
    logic [71:0] line;
    line = '0;
    for (int n = 7; n >= 0; n--) begin
      line = {line[63:0], hexChar(v[n*4 +: 4])};
    end
    return {line[63:0], srvPkg::CHAR_CR};
  endfunction

  function automatic string hexText(input logic [31:0] v);
    string s;
    s = "";
    for (int n = 7; n >= 0; n--) begin
      s = $sformatf("%s%c", s, hexChar(v[n*4 +: 4]));
    end
    return s;
  endfunction

  task automatic sendByte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge clk);
      rxd = frame[i];
      repeat (srvPkg::CLKS_PER_BIT - 1) @(negedge clk);
    end
  endtask

  // send one line, wait for its reply, then compare reply and registers
  task automatic runCmd(input string line, input logic [71:0] expLine, input int expLen);
    logic [71:0] gotLine;
    int          gotLen;
    for (int i = 0; i < line.len(); i++) begin
      sendByte(line[i]);
    end
    sendByte(srvPkg::CHAR_CR);
    while (replyQ.size() == 0) @(negedge clk);
    gotLine = replyQ.pop_front();
    gotLen  = lenQ.pop_front();
    cmdCount++;
    replyMatch: assert (gotLine == expLine && gotLen == expLen)
      else begin
        errors++;
        $display("Error txd reply to \"%s\": expected %h (%0h bytes), got %h (%0h bytes)",
                 line, expLine, expLen, gotLine, gotLen);
      end
    for (int r = 0; r < srvPkg::NUM_REGS; r++) begin
      regMatch: assert (probeReg[r] == model[r])
        else begin
          errors++;
          $display("Error probeReg[%0d]: expected %h, got %h", r, model[r], probeReg[r]);
        end
    end
  endtask

  task automatic readAll();
    for (int r = 0; r < srvPkg::NUM_REGS; r++) begin
      runCmd($sformatf("R %0d", r), valueLine(model[r]), 9);
    end
  endtask

  task automatic writeReg(input int r, input logic [31:0] v, input int style);
    string line;
    if (style == 0) line = $sformatf("W %0d %s", r, hexText(v));
    else if (style == 1) line = $sformatf("W %0d %08h", r, v);  // lower case digits
    else line = $sformatf(" W  %0d %04h  %04h ", r, v[31:16], v[15:0]);
    model[r] = v;
    runCmd(line, OK_LINE, 2);
  endtask

  task automatic aluOp(input logic [7:0] opChar, input int d, input int s, input int t);
    logic [31:0] res;
    case (opChar)
      srvPkg::CHAR_A: res = model[s] + model[t];
      srvPkg::CHAR_S: res = model[s] - model[t];
      default:        res = model[s] ^ model[t];
    endcase
    model[d] = res;
    runCmd($sformatf("%c %0d %0d %0d", opChar, d, s, t), OK_LINE, 2);
  endtask

  // decode replies from txd on falling edges
  initial begin : txMonitor
    logic [7:0]  b;
    logic [71:0] line;
    int          len;
    line = '0;
    len  = 0;
    forever begin
      @(negedge clk);
      if (arstN && !txd) begin
        repeat (srvPkg::CLKS_PER_BIT / 2 - 1) @(negedge clk);  // mid start bit
        startBit: assert (!txd)
          else begin
            errors++;
            $display("Error txd start bit: expected 0, got %h", txd);
          end
        for (int i = 0; i < 8; i++) begin
          repeat (srvPkg::CLKS_PER_BIT) @(negedge clk);
          b = {txd, b[7:1]};
        end
        repeat (srvPkg::CLKS_PER_BIT) @(negedge clk);
        stopBit: assert (txd)
          else begin
            errors++;
            $display("Error txd stop bit: expected 1, got %h", txd);
          end
        line = {line[63:0], b};
        len++;
        if (b == srvPkg::CHAR_CR) begin
          replyQ.push_back(line);
          lenQ.push_back(len);
          line = '0;
          len  = 0;
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("timeout: the server stopped answering commands");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin : stimulus
    string longLine;
    rxd = 1'b1;
    for (int r = 0; r < srvPkg::NUM_REGS; r++) begin
      model[r] = '0;
    end
    void'($urandom(32'heee1_bd0d));
    @(posedge arstN);
    @(negedge clk);
    txIdle: assert (txd)
      else begin
        errors++;
        $display("Error txd after reset: expected 1, got %h", txd);
      end
    readAll();

    for (int r = 0; r < srvPkg::NUM_REGS; r++) begin
      writeReg(r, $urandom(), r % 3);
    end
    readAll();

    writeReg(0, 32'hFFFF_FFFF, 0);
    writeReg(1, 32'h0000_0003, 1);
    aluOp(srvPkg::CHAR_A, 2, 0, 1);  // wraps to 2
    aluOp(srvPkg::CHAR_S, 3, 1, 0);  // borrow gives 4
    aluOp(srvPkg::CHAR_X, 4, 2, 3);
    aluOp(srvPkg::CHAR_A, 1, 1, 1);  // dst is both sources
    aluOp(srvPkg::CHAR_S, 5, 5, 7);
    aluOp(srvPkg::CHAR_X, 6, 6, 6);
    aluOp(srvPkg::CHAR_A, 7, 3, 7);
    aluOp(srvPkg::CHAR_S, 0, 2, 0);
    for (int i = 0; i < NUM_RAND_OPS; i++) begin
      case ($urandom_range(0, 2))
        0: aluOp(srvPkg::CHAR_A, $urandom_range(0, 7), $urandom_range(0, 7),
                 $urandom_range(0, 7));
        1: aluOp(srvPkg::CHAR_S, $urandom_range(0, 7), $urandom_range(0, 7),
                 $urandom_range(0, 7));
        default: aluOp(srvPkg::CHAR_X, $urandom_range(0, 7), $urandom_range(0, 7),
                       $urandom_range(0, 7));
      endcase
    end
    readAll();

    runCmd("Q 1", BAD_LINE, 2);
    runCmd("R 8", BAD_LINE, 2);
    runCmd("W 2 12G45678", BAD_LINE, 2);
    runCmd("A 1 2", BAD_LINE, 2);
    longLine = "R 1";
    for (int i = 0; i < srvPkg::MAX_LINE; i++) begin
      longLine = {longLine, " "};
    end
    runCmd(longLine, BAD_LINE, 2);
    readAll();

    $display("errors: %0d, commands: %0d", errors, cmdCount);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
